/* hw/replay_cfg.svh */
////////////////////////////////////////////////////////////
// sizes and field widths of the replay buffer
// REPLAY_ROWS must be a power of two, the pointers wrap
// the sum of the field widths sets the micro-op width (79)
// REPLAY_SKIP_LEVEL must stay below REPLAY_ROWS
////////////////////////////////////////////////////////////
`ifndef REPLAY_CFG_SVH
`define REPLAY_CFG_SVH

// buffer geometry
`define REPLAY_ROWS       8
`define REPLAY_LANES      3
`define REPLAY_SKIP_LEVEL 4

// micro-op payload fields
`define VADDR_W 44
`define REG_W   9
`define LSQ_W   9
`define WQ_W    6
`define ATTR_W  4
`define SZ_W    5
`define TYPE_W  2

`endif

/* hw/replay_mop_pkg.sv */
////////////////////////////////////////////////////////////
// payload types of one memory micro-op
// field order in mop_t follows the capture order of the core
////////////////////////////////////////////////////////////
`default_nettype none

`include "replay_cfg.svh"

package replay_mop_pkg;

  typedef logic [`VADDR_W-1:0] vaddr_t;
  typedef logic [`REG_W-1:0]   reg_no_t;
  typedef logic [`TYPE_W-1:0]  op_type_t;
  typedef logic [`SZ_W-1:0]    op_size_t;
  typedef logic [`LSQ_W-1:0]   lsq_idx_t;
  typedef logic [`WQ_W-1:0]    wq_idx_t;
  typedef logic [`ATTR_W-1:0]  attr_t;

  // address sits in the top bits, attribute in the bottom
  typedef struct packed {
    vaddr_t   addr;
    reg_no_t  reg_no;
    op_type_t op_type;
    op_size_t size;
    lsq_idx_t lsq;
    wq_idx_t  wq;
    attr_t    attr;
  } mop_t;

endpackage

`default_nettype wire

/* hw/replay_queue_pkg.sv */
////////////////////////////////////////////////////////////
// row pointer, lane mask and occupancy types of the buffer
// occupancy needs one bit more than the row pointer
////////////////////////////////////////////////////////////
`default_nettype none

`include "replay_cfg.svh"

package replay_queue_pkg;

  typedef logic [$clog2(`REPLAY_ROWS)-1:0]   row_idx_t;
  typedef logic [`REPLAY_LANES-1:0]          lane_mask_t;
  typedef logic [$clog2(`REPLAY_ROWS+1)-1:0] occ_t;

  // replay sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_REPLAY,
    SEQ_FLUSH
  } seq_state_t;

endpackage

`default_nettype wire

/* hw/replay_row_if.sv */
////////////////////////////////////////////////////////////
// one row write from the capture stage into the row store
// no handshake, skip keeps a free row available
// wr_row is driven from outside by the sequencer tail
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

interface replay_row_if;

  logic                         wr_en;
  replay_queue_pkg::row_idx_t   wr_row;
  replay_mop_pkg::mop_t         wr_lanes [`REPLAY_LANES];
  replay_queue_pkg::lane_mask_t wr_mask;

  modport capture (
    output wr_en,
    output wr_lanes,
    output wr_mask,
    input  wr_row
  );

  modport store (
    input wr_en,
    input wr_row,
    input wr_lanes,
    input wr_mask
  );

endinterface

`default_nettype wire

/* hw/replay_capture.sv */
////////////////////////////////////////////////////////////
// registers the incoming lanes and their conflict flags
// the row write goes out one cycle after capture
// lanes presented during rs_stall are dropped
// except cancels both the incoming and the registered row
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

module replay_capture (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire replay_queue_pkg::lane_mask_t in_conflict,
  input  wire replay_mop_pkg::mop_t         in_mop0,
  input  wire replay_mop_pkg::mop_t         in_mop1,
  input  wire replay_mop_pkg::mop_t         in_mop2,
  input  wire logic                         rs_stall,
  input  wire logic                         except,
  replay_row_if.capture                     wr
);

  replay_queue_pkg::lane_mask_t cap_mask;
  replay_mop_pkg::mop_t         cap_lanes [`REPLAY_LANES];

  // flags are control state
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_mask <= '0;
    end else if (except) begin
      cap_mask <= '0;
    end else if (!rs_stall) begin
      cap_mask <= in_conflict;
    end
  end

  // payload only, stale lanes are harmless with a zero mask
  always_ff @(posedge clk) begin
    if (!rs_stall) begin
      cap_lanes[0] <= in_mop0;
      cap_lanes[1] <= in_mop1;
      cap_lanes[2] <= in_mop2;
    end
  end

  // a stalled row waits in the register, written once
  assign wr.wr_en    = (|cap_mask) && !rs_stall && !except;
  assign wr.wr_mask  = cap_mask;
  assign wr.wr_lanes = cap_lanes;

endmodule

`default_nettype wire

/* hw/replay_row_store.sv */
////////////////////////////////////////////////////////////
// eight-row store of lanes and conflict masks
// read address is registered when rd_en is high
// a read of a row written on the same edge sees the new data
// no reset on the rows, the sequencer valid bits cover them
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

module replay_row_store (
  input  wire logic                         clk,
  input  wire logic                         rst,
  replay_row_if.store                       wr,
  input  wire logic                         rd_en,
  input  wire replay_queue_pkg::row_idx_t   rd_row_next,
  output      replay_mop_pkg::mop_t         rd_lanes [`REPLAY_LANES],
  output      replay_queue_pkg::lane_mask_t rd_mask
);

  replay_mop_pkg::mop_t         lane_mem [`REPLAY_ROWS][`REPLAY_LANES];
  replay_queue_pkg::lane_mask_t mask_mem [`REPLAY_ROWS];
  replay_queue_pkg::row_idx_t   rd_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_row_next;
    end
  end

  // whole row in one write
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      mask_mem[wr.wr_row] <= wr.wr_mask;
      for (int l = 0; l < `REPLAY_LANES; l++) begin
        lane_mem[wr.wr_row][l] <= wr.wr_lanes[l];
      end
    end
  end

  // asynchronous read behind the registered address
  for (genvar l = 0; l < `REPLAY_LANES; l++) begin : g_rd_lane
    assign rd_lanes[l] = lane_mem[rd_addr_q][l];
  end

  assign rd_mask = mask_mem[rd_addr_q];

endmodule

`default_nettype wire

/* hw/replay_sequencer.sv */
////////////////////////////////////////////////////////////
// head/tail pointers, row valid bits and replay order
// oldest row first, lowest flagged lane first
// rs_stall freezes pointers, masks and the outputs
// except drops every pending row at the same edge
// skip has hysteresis: set at the skip level, cleared at zero
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

module replay_sequencer (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         row_push,
  input  wire replay_mop_pkg::mop_t         rd_lanes [`REPLAY_LANES],
  input  wire replay_queue_pkg::lane_mask_t rd_mask,
  input  wire logic                         rs_stall,
  input  wire logic                         except,
  output      replay_queue_pkg::row_idx_t   wr_row,
  output      logic                         rd_en,
  output      replay_queue_pkg::row_idx_t   rd_row_next,
  output      logic                         out_valid,
  output      replay_mop_pkg::mop_t         out_mop,
  output      logic                         skip
);

  localparam int LANE_W = $clog2(`REPLAY_LANES);

  replay_queue_pkg::row_idx_t   head;
  replay_queue_pkg::row_idx_t   tail;
  replay_queue_pkg::occ_t       occ;
  replay_queue_pkg::lane_mask_t rem_mask;
  replay_queue_pkg::lane_mask_t cur_mask;
  replay_queue_pkg::lane_mask_t sel_bit;
  replay_queue_pkg::seq_state_t state;
  logic [`REPLAY_ROWS-1:0]      valid;
  logic [LANE_W-1:0]            sel_lane;
  logic                         pop;
  logic                         last_lane;

  // a freshly reached head row takes its mask from the store
  assign cur_mask = (state == replay_queue_pkg::SEQ_REPLAY) ? rem_mask : rd_mask;

  // lowest remaining lane
  always_comb begin
    sel_lane = '0;
    for (int l = `REPLAY_LANES - 1; l >= 0; l--) begin
      if (cur_mask[l]) begin
        sel_lane = LANE_W'(l);
      end
    end
  end

  assign sel_bit   = replay_queue_pkg::lane_mask_t'(1) << sel_lane;
  assign last_lane = (cur_mask & ~sel_bit) == '0;

  assign out_valid = valid[head] && !except && (state != replay_queue_pkg::SEQ_FLUSH);
  assign out_mop   = rd_lanes[sel_lane];
  assign pop       = out_valid && !rs_stall;

  // next head goes straight to the store read address
  always_comb begin
    if (except) begin
      rd_row_next = tail;
    end else if (pop && last_lane) begin
      rd_row_next = replay_queue_pkg::row_idx_t'(head + 1'b1);
    end else begin
      rd_row_next = head;
    end
  end

  assign rd_en  = !rs_stall || except;
  assign wr_row = tail;

  always_ff @(posedge clk) begin
    if (rst) begin
      head     <= '0;
      tail     <= '0;
      valid    <= '0;
      occ      <= '0;
      rem_mask <= '0;
      state    <= replay_queue_pkg::SEQ_IDLE;
    end else if (except) begin
      // capture has no row in flight, so tail stays
      head     <= tail;
      valid    <= '0;
      occ      <= '0;
      rem_mask <= '0;
      state    <= replay_queue_pkg::SEQ_FLUSH;
    end else if (state == replay_queue_pkg::SEQ_FLUSH) begin
      state <= replay_queue_pkg::SEQ_IDLE;
    end else if (!rs_stall) begin
      if (row_push) begin
        valid[tail] <= 1'b1;
        tail        <= replay_queue_pkg::row_idx_t'(tail + 1'b1);
      end
      if (pop) begin
        if (last_lane) begin
          valid[head] <= 1'b0;
          head        <= rd_row_next;
          state       <= replay_queue_pkg::SEQ_IDLE;
        end else begin
          rem_mask <= cur_mask & ~sel_bit;
          state    <= replay_queue_pkg::SEQ_REPLAY;
        end
      end
      case ({row_push, pop && last_lane})
        2'b10:   occ <= replay_queue_pkg::occ_t'(occ + 1'b1);
        2'b01:   occ <= replay_queue_pkg::occ_t'(occ - 1'b1);
        default: occ <= occ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      skip <= 1'b0;
    end else if (occ >= replay_queue_pkg::occ_t'(`REPLAY_SKIP_LEVEL)) begin
      skip <= 1'b1;
    end else if (occ == '0) begin
      skip <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/replay_cam.sv */
////////////////////////////////////////////////////////////
// load/store replay buffer top level
// the sender must stop raising conflict flags while skip
// is high and hold its lanes through rs_stall
// out_mop is meaningful only with out_valid
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

module replay_cam (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire replay_queue_pkg::lane_mask_t in_conflict,
  input  wire replay_mop_pkg::mop_t         in_mop0,
  input  wire replay_mop_pkg::mop_t         in_mop1,
  input  wire replay_mop_pkg::mop_t         in_mop2,
  input  wire logic                         rs_stall,
  input  wire logic                         except,
  output      logic                         out_valid,
  output      replay_mop_pkg::mop_t         out_mop,
  output      logic                         skip
);

  replay_row_if row_if ();

  replay_mop_pkg::mop_t         rd_lanes [`REPLAY_LANES];
  replay_queue_pkg::lane_mask_t rd_mask;
  replay_queue_pkg::row_idx_t   rd_row_next;
  logic                         rd_en;

  replay_capture u_capture (
    .clk         (clk),
    .rst         (rst),
    .in_conflict (in_conflict),
    .in_mop0     (in_mop0),
    .in_mop1     (in_mop1),
    .in_mop2     (in_mop2),
    .rs_stall    (rs_stall),
    .except      (except),
    .wr          (row_if.capture)
  );

  replay_row_store u_store (
    .clk         (clk),
    .rst         (rst),
    .wr          (row_if.store),
    .rd_en       (rd_en),
    .rd_row_next (rd_row_next),
    .rd_lanes    (rd_lanes),
    .rd_mask     (rd_mask)
  );

  // tail pointer feeds the row write address
  replay_sequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .row_push    (row_if.wr_en),
    .rd_lanes    (rd_lanes),
    .rd_mask     (rd_mask),
    .rs_stall    (rs_stall),
    .except      (except),
    .wr_row      (row_if.wr_row),
    .rd_en       (rd_en),
    .rd_row_next (rd_row_next),
    .out_valid   (out_valid),
    .out_mop     (out_mop),
    .skip        (skip)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
////////////////////////////////////////////////////////////
// free running testbench clock, 20 ns period
// starts low, first rising edge at 10 ns
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  localparam int HALF_NS = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

endmodule

`default_nettype wire

/* verif/replay_cam_assert.sv */
////////////////////////////////////////////////////////////
// concurrent checks on the replay sequencer
// bound into replay_sequencer, sees its occupancy directly
// fail_count counts failed assertions for the testbench
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "replay_cfg.svh"

module replay_cam_assert (
  input wire logic                   clk,
  input wire logic                   rst,
  input wire logic                   row_push,
  input wire replay_queue_pkg::occ_t occ,
  input wire logic                   except,
  input wire logic                   rs_stall,
  input wire logic                   out_valid,
  input wire replay_mop_pkg::mop_t   out_mop,
  input wire logic                   skip
);

  int fail_count = 0;

  // the skip protocol must leave a free row for every push
  no_push_when_full : assert property (@(posedge clk) disable iff (rst)
    row_push |-> (occ != replay_queue_pkg::occ_t'(`REPLAY_ROWS)))
    else begin
      $error("row pushed while every row is pending");
      fail_count++;
    end

  no_valid_in_flush : assert property (@(posedge clk) disable iff (rst)
    except |-> !out_valid)
    else begin
      $error("out_valid high while except is high");
      fail_count++;
    end

  // a stalled edge changes nothing, so the op must repeat
  mop_held_in_stall : assert property (@(posedge clk) disable iff (rst)
    (out_valid && rs_stall && !except) |=> $stable(out_mop))
    else begin
      $error("out_mop changed across a stalled edge");
      fail_count++;
    end

  skip_low_after_reset : assert property (@(posedge clk)
    rst |=> !skip)
    else begin
      $error("skip high right after reset");
      fail_count++;
    end

endmodule

`default_nettype wire

/* verif/replay_cam_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the load/store replay buffer
// the sender holds its lanes through rs_stall and waits for
// skip to be low before raising conflict flags
// expected ops are queued at each capture edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module replay_cam_tb;

  localparam int          RAND_ROWS   = 200;
  localparam int          STALL_ROWS  = 60;
  localparam int          STIM_CYCLES = 100 + RAND_ROWS * 3 + STALL_ROWS * 6;
  localparam int          WATCHDOG_NS = STIM_CYCLES * 20 * 4;
  localparam int          WAIT_LIMIT  = 64;
  localparam int          DRIVE_DLY   = 2;
  localparam int          SKIP_ROWS   = 4;
  localparam logic [31:0] SEED        = 32'hb7d3_2401;

  logic                         clk;
  logic                         rst;
  replay_queue_pkg::lane_mask_t in_conflict;
  replay_mop_pkg::mop_t         in_mop0;
  replay_mop_pkg::mop_t         in_mop1;
  replay_mop_pkg::mop_t         in_mop2;
  logic                         rs_stall;
  logic                         except;
  logic                         out_valid;
  replay_mop_pkg::mop_t         out_mop;
  logic                         skip;

  logic [31:0]                  lcg_state;
  replay_mop_pkg::mop_t         exp_q [$];
  logic                         last_op_q [$];
  int                           pend_rows;
  logic                         row_in_flight;
  logic                         exp_skip;
  string                        test_name;

  tb_clk_gen u_clk_gen (.clk (clk));

  replay_cam DUT (
    .clk         (clk),
    .rst         (rst),
    .in_conflict (in_conflict),
    .in_mop0     (in_mop0),
    .in_mop1     (in_mop1),
    .in_mop2     (in_mop2),
    .rs_stall    (rs_stall),
    .except      (except),
    .out_valid   (out_valid),
    .out_mop     (out_mop),
    .skip        (skip)
  );

  bind replay_sequencer replay_cam_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .row_push  (row_push),
    .occ       (occ),
    .except    (except),
    .rs_stall  (rs_stall),
    .out_valid (out_valid),
    .out_mop   (out_mop),
    .skip      (skip)
  );

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic replay_mop_pkg::mop_t rand_mop();
    logic [95:0] bits;
    bits = {rand_word(), rand_word(), rand_word()};
    return replay_mop_pkg::mop_t'(bits[78:0]);
  endfunction

  // expected ops of one row in ascending lane order
  // the highest flagged lane frees the row
  function automatic void queue_row(input replay_queue_pkg::lane_mask_t mask,
                                    input replay_mop_pkg::mop_t l0,
                                    input replay_mop_pkg::mop_t l1,
                                    input replay_mop_pkg::mop_t l2);
    replay_mop_pkg::mop_t lanes [3];
    lanes[0] = l0;
    lanes[1] = l1;
    lanes[2] = l2;
    for (int l = 0; l < 3; l++) begin
      if (mask[l]) begin
        exp_q.push_back(lanes[l]);
        last_op_q.push_back((mask >> (l + 1)) == '0);
      end
    end
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [95:0] expected,
                             input logic [95:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAIL %s/%s expected %h actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wait_skip(input logic level, input string reason);
    int n;
    n = 0;
    while (skip !== level) begin
      if (n >= WAIT_LIMIT) begin
        abort_run(reason);
      end else begin
        next_cycle();
        n++;
      end
    end
  endtask

  // lanes are held through the stall and captured on the edge after it
  task automatic send_row(input replay_queue_pkg::lane_mask_t mask, input int stall_cycles);
    in_conflict = '0;
    wait_skip(1'b0, "skip stayed high, the buffer never drained");
    in_conflict = mask;
    in_mop0     = rand_mop();
    in_mop1     = rand_mop();
    in_mop2     = rand_mop();
    rs_stall    = (stall_cycles > 0);
    repeat (stall_cycles) next_cycle();
    rs_stall = 1'b0;
    next_cycle();
    in_conflict = '0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    in_conflict = '0;
    while (exp_q.size() != 0) begin
      if (n >= WAIT_LIMIT) begin
        abort_run("expected ops were never replayed");
      end else begin
        next_cycle();
        n++;
      end
    end
    check_equal("drain_valid", 1'b0, out_valid);
  endtask

  // compares skip and each replayed op, then records a captured row
  always @(posedge clk) begin
    if (!rst) begin
      check_equal("skip", exp_skip, skip);
      // skip follows the rows pending before this edge
      if (pend_rows >= SKIP_ROWS) begin
        exp_skip = 1'b1;
      end else if (pend_rows == 0) begin
        exp_skip = 1'b0;
      end
      if (except) begin
        check_equal("valid_in_flush", 1'b0, out_valid);
        exp_q.delete();
        last_op_q.delete();
        pend_rows     = 0;
        row_in_flight = 1'b0;
      end else if (!rs_stall) begin
        // a row captured on the previous edge is written now
        if (row_in_flight) begin
          pend_rows++;
        end
        if (out_valid) begin
          if (exp_q.size() == 0) begin
            abort_run("an op was replayed while none was expected");
          end else begin
            check_equal("replay_op", exp_q[0], out_mop);
            if (last_op_q[0]) begin
              pend_rows--;
            end
            void'(exp_q.pop_front());
            void'(last_op_q.pop_front());
          end
        end
        row_in_flight = (in_conflict != '0);
        if (row_in_flight) begin
          queue_row(in_conflict, in_mop0, in_mop1, in_mop2);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("timeout after %0d ns, the tests did not finish", WATCHDOG_NS));
  end

  initial begin
    logic [31:0] r;
    int          n;
    lcg_state     = SEED;
    pend_rows     = 0;
    row_in_flight = 1'b0;
    exp_skip      = 1'b0;
    rst           = 1'b1;
    in_conflict   = '0;
    in_mop0       = '0;
    in_mop1       = '0;
    in_mop2       = '0;
    rs_stall      = 1'b0;
    except        = 1'b0;
    test_name     = "reset";
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    check_equal("out_valid", 1'b0, out_valid);
    check_equal("skip", 1'b0, skip);

    test_name = "single_lane";
    send_row(3'b010, 0);
    drain();

    test_name = "three_lanes";
    send_row(3'b111, 0);
    drain();

    test_name = "random_rows";
    for (int i = 0; i < RAND_ROWS; i++) begin
      r = rand_word();
      if (r[31:30] == 2'b00) begin
        next_cycle();
      end
      send_row(r[29:27], 0);
    end
    drain();

    test_name = "stall_pulses";
    for (int i = 0; i < STALL_ROWS; i++) begin
      r = rand_word();
      send_row(r[29:27], (r[31:30] == 2'b00) ? 0 : int'(r[26:25]) + 1);
    end
    drain();

    // skip clears on the edge after the buffer empties
    test_name = "skip_level";
    wait_skip(1'b0, "skip did not fall before the skip test");
    n = 0;
    while (!skip && (n < 8)) begin
      send_row(3'b111, 0);
      n++;
    end
    wait_skip(1'b1, "skip never rose with four rows pending");
    drain();
    check_equal("skip_held", 1'b1, skip);
    next_cycle();
    check_equal("skip_fall", 1'b0, skip);

    test_name = "flush";
    send_row(3'b111, 0);
    send_row(3'b101, 0);
    send_row(3'b011, 0);
    except = 1'b1;
    repeat (2) next_cycle();
    except = 1'b0;
    next_cycle();
    check_equal("flushed_valid", 1'b0, out_valid);
    send_row(3'b110, 0);
    send_row(3'b001, 0);
    drain();

    if (DUT.u_sequencer.u_assert.fail_count != 0) begin
      abort_run("a bound assertion failed during the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* replay_cam.f */
+incdir+hw
hw/replay_mop_pkg.sv
hw/replay_queue_pkg.sv
hw/replay_row_if.sv
hw/replay_capture.sv
hw/replay_row_store.sv
hw/replay_sequencer.sv
hw/replay_cam.sv
verif/tb_clk_gen.sv
verif/replay_cam_assert.sv
verif/replay_cam_tb.sv

/* Bender.yml */
package:
  name: replay_cam

sources:
  - include_dirs:
      - hw
    files:
      - hw/replay_mop_pkg.sv
      - hw/replay_queue_pkg.sv
      - hw/replay_row_if.sv
      - hw/replay_capture.sv
      - hw/replay_row_store.sv
      - hw/replay_sequencer.sv
      - hw/replay_cam.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_clk_gen.sv
      - verif/replay_cam_assert.sv
      - verif/replay_cam_tb.sv
